// File: sources.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/rv_imm_gen.sv
logic/rv_ctrl_decode.sv
logic/rv_decode_stage.sv
test/rv_decode_checker.sv
test/tb_rv_decode.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_decode
LOG       ?= sim.log
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Testbench passed

VFLAGS    ?= --timing --assert -f $(FLIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_rv_decode.sv
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module tb_rv_decode;

    import rv_decode_pkg::*;

    localparam int NUM_SEQ    = 400;
    localparam int CLK_PERIOD = 20;

    logic         clk;
    logic         arst_n;
    inst_t        inst;
    logic         in_valid;
    logic         stall;
    logic         out_valid;
    decode_ctrl_t ctrl;
    logic [15:0]  lfsr;

    rv_decode_stage uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst      (inst),
        .in_valid  (in_valid),
        .stall     (stall),
        .out_valid (out_valid),
        .ctrl      (ctrl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic compose_word(output inst_t w);
        logic [31:0] kind;
        logic [31:0] raw;
        take_bits(4, kind);
        take_bits(32, raw);
        w = raw;
        case (kind[3:0])
            4'd0: begin
                w[6:0]   = OPC_OP;
                w[31:25] = (w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
            end
            4'd1: begin
                w[6:0] = OPC_OP_IMM;
                if (w[14:12] == 3'd1) begin
                    w[31:25] = 7'h00;
                end else if (w[14:12] == 3'd5) begin
                    w[31:25] = {1'b0, w[30], 5'd0};
                end
            end
            4'd2: w[6:0] = OPC_LUI;
            4'd3: w[6:0] = OPC_AUIPC;
            4'd4: begin
                w[6:0] = OPC_LOAD;
                // 3, 6 and 7 fold onto LH, LBU and LHU
                if (w[14:12] == 3'd3 || w[14:13] == 2'b11) begin
                    w[13] = 1'b0;
                end
            end
            4'd5: begin
                w[6:0] = OPC_STORE;
                w[14]  = 1'b0;
                if (w[13:12] == 2'b11) begin
                    w[13] = 1'b0;
                end
            end
            4'd6: begin
                w[6:0] = OPC_BRANCH;
                if (w[14:13] == 2'b01) begin
                    w[14] = 1'b1;
                end
            end
            4'd7: w[6:0] = OPC_JAL;
            4'd8: begin
                w[6:0]   = OPC_JALR;
                w[14:12] = 3'd0;
            end
            4'd9: w = `RV_EBREAK;
            // system words other than ebreak, almost always
            4'd10: w[6:0] = OPC_SYSTEM;
            // low opcode bits not 11, never a listed opcode
            4'd11: w[1] = 1'b0;
            default: begin
                w = raw;
            end
        endcase
    endtask

    initial begin
        inst_t       w;
        logic [31:0] pick_s;
        logic [31:0] pick_v;
        clk      = 1'b0;
        arst_n   = 1'b1;
        lfsr     = 16'd82;
        in_valid = 1'b1;
        stall    = 1'b0;
        inst     = `RV_EBREAK;
        #1;
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < NUM_SEQ; i++) begin
            @(posedge clk);
            take_bits(3, pick_s);
            take_bits(3, pick_v);
            compose_word(w);
            stall    <= (pick_s[2:0] == 3'd0);
            in_valid <= (pick_v[2:0] != 3'd0);
            inst     <= w;
        end
        // let the last word reach the checker
        repeat (2) @(posedge clk);
        if (uut.u_chk.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "checker reported %0d assertion failures", uut.u_chk.fail_count);
        end
    end

    initial begin
        wait (uut.u_chk.fail_count != 0);
        $display("Testbench failed");
        $fatal(1, "an assertion in the decode checker failed");
    end

    initial begin
        #((NUM_SEQ + 20) * CLK_PERIOD);
        $display("watchdog expired before all words were applied");
        $display("Testbench failed");
        $fatal(1, "simulation timed out");
    end

endmodule

// File: test/rv_decode_checker.sv
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_decode_checker (
    input logic                        clk,
    input logic                        arst_n,
    input rv_decode_pkg::inst_t        inst,
    input logic                        in_valid,
    input logic                        stall,
    input logic                        out_valid,
    input rv_decode_pkg::decode_ctrl_t ctrl
);

    import rv_decode_pkg::*;

    int           fail_count = 0;
    inst_t        inst_q;
    decode_ctrl_t ctrl_q;
    logic         ov_q;
    logic         ld_q;
    logic         bub_q;
    logic         hold_q;
    logic [6:0]   opc_q;
    funct3_t      f3_q;
    funct7_t      f7_q;
    word_t        i_imm;
    word_t        s_imm;
    word_t        b_imm;
    word_t        u_imm;
    word_t        j_imm;
    logic         e_legal;
    alu_op_e      e_alu;
    dmem_e        e_mem;
    br_e          e_br;
    wd_sel_e      e_wd;
    logic         e_we;
    logic         e_src0;
    logic         e_src1;
    word_t        e_imm;
    logic [23:0]  alu_exp;
    logic [23:0]  alu_act;
    logic [14:0]  ctl_exp;
    logic [14:0]  ctl_act;
    logic [7:0]   ill_act;
    logic [9:0]   bub_act;
    logic [$bits(decode_ctrl_t):0] hold_exp;
    logic [$bits(decode_ctrl_t):0] hold_act;

    function automatic alu_op_e alu_for(input funct3_t f, input logic alt);
        case (f)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // copy of what the stage sampled at the last edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_q <= '0;
            ctrl_q <= CTRL_BUBBLE;
            ov_q   <= 1'b0;
            ld_q   <= 1'b0;
            bub_q  <= 1'b0;
            hold_q <= 1'b0;
        end else begin
            inst_q <= inst;
            ctrl_q <= ctrl;
            ov_q   <= out_valid;
            ld_q   <= in_valid && !stall;
            bub_q  <= !in_valid && !stall;
            hold_q <= stall;
        end
    end

    assign opc_q = inst_q[6:0];
    assign f3_q  = inst_q[14:12];
    assign f7_q  = inst_q[31:25];
    assign i_imm = {{20{inst_q[31]}}, inst_q[31:20]};
    assign s_imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign b_imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    assign u_imm = {inst_q[31:12], 12'd0};
    assign j_imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

    // expected fields of the last loaded word
    always_comb begin
        e_legal = 1'b1;
        e_alu   = ALU_ADD;
        e_mem   = MEM_NONE;
        e_br    = BR_NONE;
        e_wd    = WD_ALU;
        e_we    = 1'b1;
        e_src0  = 1'b0;
        e_src1  = 1'b1;
        e_imm   = '0;
        case (opc_q)
            OPC_OP: begin
                e_legal = f7_q == 7'h00 || (f7_q == 7'h20 && (f3_q == 3'd0 || f3_q == 3'd5));
                e_alu   = alu_for(f3_q, f7_q[5]);
                e_src1  = 1'b0;
            end
            OPC_OP_IMM: begin
                if (f3_q == 3'd1 || f3_q == 3'd5) begin
                    e_legal = f7_q == 7'h00 || (f3_q == 3'd5 && f7_q == 7'h20);
                    e_imm   = {27'd0, inst_q[24:20]};
                end else begin
                    e_imm = i_imm;
                end
                e_alu = alu_for(f3_q, f3_q == 3'd5 && f7_q[5]);
            end
            OPC_LUI: e_imm = u_imm;
            OPC_AUIPC: begin
                e_src0 = 1'b1;
                e_imm  = u_imm;
            end
            OPC_LOAD: begin
                e_wd  = WD_MEM;
                e_imm = i_imm;
                case (f3_q)
                    3'd0:    e_mem = LB;
                    3'd1:    e_mem = LH;
                    3'd2:    e_mem = LW;
                    3'd4:    e_mem = LBU;
                    3'd5:    e_mem = LHU;
                    default: e_legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                e_we  = 1'b0;
                e_wd  = WD_NONE;
                e_imm = s_imm;
                case (f3_q)
                    3'd0:    e_mem = SB;
                    3'd1:    e_mem = SH;
                    3'd2:    e_mem = SW;
                    default: e_legal = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                e_we   = 1'b0;
                e_wd   = WD_PC4;
                e_src0 = 1'b1;
                e_imm  = b_imm;
                case (f3_q)
                    3'd0:    e_br = BEQ;
                    3'd1:    e_br = BNE;
                    3'd4:    e_br = BLT;
                    3'd5:    e_br = BGE;
                    3'd6:    e_br = BLTU;
                    3'd7:    e_br = BGEU;
                    default: e_legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                e_wd   = WD_PC4;
                e_br   = JAL;
                e_src0 = 1'b1;
                e_imm  = j_imm;
            end
            OPC_JALR: begin
                e_legal = f3_q == 3'd0;
                e_wd    = WD_PC4;
                e_br    = JALR;
                e_imm   = i_imm;
            end
            OPC_SYSTEM: begin
                e_legal = inst_q == `RV_EBREAK;
                e_we    = 1'b0;
                e_wd    = WD_PC4;
                e_alu   = ALU_HALT;
                e_src1  = 1'b0;
            end
            default: e_legal = 1'b0;
        endcase
    end

    assign alu_exp  = {e_alu, opc_q == OPC_OP_IMM, 1'b1, WD_ALU,
                       inst_q[19:15], inst_q[24:20], inst_q[11:7]};
    assign alu_act  = {ctrl.alu_op, ctrl.alu_src1_sel, ctrl.rf_we, ctrl.rf_wd_sel,
                       ctrl.rf_ra0, ctrl.rf_ra1, ctrl.rf_wa};
    assign ctl_exp  = {1'b1, 1'b0, e_src0, e_src1, e_mem, e_br, e_wd, e_we};
    assign ctl_act  = {out_valid, ctrl.illegal, ctrl.alu_src0_sel, ctrl.alu_src1_sel,
                       ctrl.dmem_access, ctrl.br_type, ctrl.rf_wd_sel, ctrl.rf_we};
    assign ill_act  = {out_valid, ctrl.illegal, ctrl.rf_we, ctrl.dmem_access, ctrl.halt};
    assign bub_act  = {out_valid, ctrl.rf_we, ctrl.dmem_access, ctrl.br_type};
    assign hold_exp = {ov_q, ctrl_q};
    assign hold_act = {out_valid, ctrl};

    a_reset_bubble: assert property (@(posedge clk)
        (!arst_n || bub_q) |-> bub_act == {2'b00, MEM_NONE, BR_NONE})
        else begin
            fail_count++;
            $error("[FAIL] reset_bubble expected %h actual %h",
                   {2'b00, MEM_NONE, BR_NONE}, $sampled(bub_act));
        end

    a_alu_group: assert property (@(posedge clk)
        (ld_q && e_legal && (opc_q == OPC_OP || opc_q == OPC_OP_IMM)) |-> alu_act == alu_exp)
        else begin
            fail_count++;
            $error("[FAIL] alu_group expected %h actual %h", $sampled(alu_exp), $sampled(alu_act));
        end

    a_imm: assert property (@(posedge clk) (ld_q && e_legal) |-> ctrl.imm == e_imm)
        else begin
            fail_count++;
            $error("[FAIL] immediate expected %h actual %h", $sampled(e_imm), $sampled(ctrl.imm));
        end

    a_mem_branch: assert property (@(posedge clk) (ld_q && e_legal) |-> ctl_act == ctl_exp)
        else begin
            fail_count++;
            $error("[FAIL] mem_branch expected %h actual %h", $sampled(ctl_exp), $sampled(ctl_act));
        end

    a_stall_hold: assert property (@(posedge clk) hold_q |-> hold_act == hold_exp)
        else begin
            fail_count++;
            $error("[FAIL] stall_hold expected %h actual %h",
                   $sampled(hold_exp), $sampled(hold_act));
        end

    a_ebreak: assert property (@(posedge clk)
        (ld_q && inst_q == `RV_EBREAK) |-> {ctrl.halt, ctrl.alu_op} == {1'b1, ALU_HALT})
        else begin
            fail_count++;
            $error("[FAIL] ebreak expected %h actual %h", {1'b1, ALU_HALT},
                   $sampled({ctrl.halt, ctrl.alu_op}));
        end

    a_illegal: assert property (@(posedge clk)
        (ld_q && !e_legal) |-> ill_act == {3'b110, MEM_NONE, 1'b0})
        else begin
            fail_count++;
            $error("[FAIL] illegal expected %h actual %h", {3'b110, MEM_NONE, 1'b0},
                   $sampled(ill_act));
        end

endmodule

bind rv_decode_stage rv_decode_checker u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .inst      (inst),
    .in_valid  (in_valid),
    .stall     (stall),
    .out_valid (out_valid),
    .ctrl      (ctrl)
);

// File: logic/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  rv_decode_pkg::inst_t        inst,
    input  logic                        in_valid,
    input  logic                        stall,
    output logic                        out_valid,
    output rv_decode_pkg::decode_ctrl_t ctrl
);

    import rv_decode_pkg::*;

    decode_ctrl_t dec_ctrl;
    decode_ctrl_t ctrl_next;
    imm_fmt_e     imm_fmt;
    word_t        imm;

    rv_ctrl_decode u_ctrl (
        .inst (inst),
        .fmt  (imm_fmt),
        .ctrl (dec_ctrl)
    );

    rv_imm_gen u_imm (
        .inst (inst),
        .fmt  (imm_fmt),
        .imm  (imm)
    );

    // imm comes from its own generator
    always_comb begin
        ctrl_next     = dec_ctrl;
        ctrl_next.imm = imm;
    end

    // hold on stall, bubble when nothing valid arrives
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            ctrl      <= CTRL_BUBBLE;
        end else if (!stall) begin
            out_valid <= in_valid;
            if (in_valid) begin
                ctrl <= ctrl_next;
            end else begin
                ctrl <= CTRL_BUBBLE;
            end
        end
    end

endmodule

// File: logic/rv_ctrl_decode.sv
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_ctrl_decode (
    input  rv_decode_pkg::inst_t        inst,
    output rv_decode_pkg::imm_fmt_e     fmt,
    output rv_decode_pkg::decode_ctrl_t ctrl
);

    import rv_decode_pkg::*;

    opcode_e opc;
    funct3_t f3;
    funct7_t f7;
    logic    legal;

    assign opc = opcode_e'(inst[`RV_OPC_LSB +: `RV_OPC_W]);
    assign f3  = inst[`RV_F3_LSB +: `RV_F3_W];
    assign f7  = inst[`RV_F7_LSB +: `RV_F7_W];

    // shared by register and immediate ALU groups
    function automatic alu_op_e alu_of(input funct3_t f, input logic alt);
        case (f)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl  = CTRL_BUBBLE;
        fmt   = IMM_ZERO;
        legal = 1'b1;

        // register fields straight from the word
        ctrl.rf_ra0 = inst[`RV_RS1_LSB +: `RV_REG_AW];
        ctrl.rf_ra1 = inst[`RV_RS2_LSB +: `RV_REG_AW];
        ctrl.rf_wa  = inst[`RV_RD_LSB +: `RV_REG_AW];

        case (opc)
            OPC_OP: begin
                legal = (f7 == `RV_F7_BASE) ||
                        (f7 == `RV_F7_ALT && (f3 == 3'b000 || f3 == 3'b101));
                ctrl.alu_op    = alu_of(f3, f7 == `RV_F7_ALT);
                ctrl.rf_we     = 1'b1;
                ctrl.rf_wd_sel = WD_ALU;
            end
            OPC_OP_IMM: begin
                // shifts keep funct7 in the immediate field
                if (f3 == 3'b001) begin
                    legal = (f7 == `RV_F7_BASE);
                    fmt   = IMM_SH;
                end else if (f3 == 3'b101) begin
                    legal = (f7 == `RV_F7_BASE) || (f7 == `RV_F7_ALT);
                    fmt   = IMM_SH;
                end else begin
                    fmt = IMM_I;
                end
                ctrl.alu_op       = alu_of(f3, f3 == 3'b101 && f7 == `RV_F7_ALT);
                ctrl.alu_src1_sel = 1'b1;
                ctrl.rf_we        = 1'b1;
                ctrl.rf_wd_sel    = WD_ALU;
            end
            OPC_LUI: begin
                ctrl.rf_ra0       = '0;
                ctrl.rf_ra1       = '0;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.rf_we        = 1'b1;
                ctrl.rf_wd_sel    = WD_ALU;
                fmt               = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl.alu_src0_sel = 1'b1;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.rf_we        = 1'b1;
                ctrl.rf_wd_sel    = WD_ALU;
                fmt               = IMM_U;
            end
            OPC_LOAD: begin
                case (f3)
                    3'b010:  ctrl.dmem_access = LW;
                    3'b001:  ctrl.dmem_access = LH;
                    3'b000:  ctrl.dmem_access = LB;
                    3'b100:  ctrl.dmem_access = LBU;
                    3'b101:  ctrl.dmem_access = LHU;
                    default: legal = 1'b0;
                endcase
                ctrl.alu_src1_sel = 1'b1;
                ctrl.rf_we        = 1'b1;
                ctrl.rf_wd_sel    = WD_MEM;
                fmt               = IMM_I;
            end
            OPC_STORE: begin
                case (f3)
                    3'b010:  ctrl.dmem_access = SW;
                    3'b001:  ctrl.dmem_access = SH;
                    3'b000:  ctrl.dmem_access = SB;
                    default: legal = 1'b0;
                endcase
                ctrl.alu_src1_sel = 1'b1;
                fmt               = IMM_S;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  ctrl.br_type = BEQ;
                    3'b001:  ctrl.br_type = BNE;
                    3'b100:  ctrl.br_type = BLT;
                    3'b101:  ctrl.br_type = BGE;
                    3'b110:  ctrl.br_type = BLTU;
                    3'b111:  ctrl.br_type = BGEU;
                    default: legal = 1'b0;
                endcase
                // target is pc + imm
                ctrl.alu_src0_sel = 1'b1;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.rf_wd_sel    = WD_PC4;
                fmt               = IMM_B;
            end
            OPC_JAL: begin
                ctrl.alu_src0_sel = 1'b1;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.rf_we        = 1'b1;
                ctrl.rf_wd_sel    = WD_PC4;
                ctrl.br_type      = JAL;
                fmt               = IMM_J;
            end
            OPC_JALR: begin
                legal             = (f3 == 3'b000);
                ctrl.alu_src1_sel = 1'b1;
                ctrl.rf_we        = 1'b1;
                ctrl.rf_wd_sel    = WD_PC4;
                ctrl.br_type      = JALR;
                fmt               = IMM_I;
            end
            OPC_SYSTEM: begin
                legal          = (inst == `RV_EBREAK);
                ctrl.rf_ra0    = '0;
                ctrl.rf_ra1    = '0;
                ctrl.rf_wa     = '0;
                ctrl.rf_wd_sel = WD_PC4;
                ctrl.alu_op    = ALU_HALT;
                ctrl.halt      = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // anything unmatched leaves the pipe as a flagged bubble
        if (!legal) begin
            ctrl         = CTRL_BUBBLE;
            ctrl.illegal = 1'b1;
            fmt          = IMM_ZERO;
        end
    end

endmodule

// File: logic/rv_imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_imm_gen (
    input  rv_decode_pkg::inst_t    inst,
    input  rv_decode_pkg::imm_fmt_e fmt,
    output rv_decode_pkg::word_t    imm
);

    import rv_decode_pkg::*;

    logic sign;

    assign sign = inst[`RV_XLEN-1];

    always_comb begin
        case (fmt)
            IMM_I: begin
                imm = {{(`RV_XLEN-12){sign}}, inst[31:20]};
            end
            // shamt only, upper bits carry funct7
            IMM_SH: begin
                imm = {{(`RV_XLEN-`RV_REG_AW){1'b0}}, inst[`RV_RS2_LSB +: `RV_REG_AW]};
            end
            IMM_S: begin
                imm = {{(`RV_XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{(`RV_XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{(`RV_XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: logic/rv_decode_pkg.sv
`include "rv_decode_params.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]   inst_t;
    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [`RV_F3_W-1:0]   funct3_t;
    typedef logic [`RV_F7_W-1:0]   funct7_t;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd2,
        ALU_SLT  = 5'd4,
        ALU_SLTU = 5'd5,
        ALU_AND  = 5'd9,
        ALU_OR   = 5'd10,
        ALU_XOR  = 5'd11,
        ALU_SLL  = 5'd14,
        ALU_SRL  = 5'd15,
        ALU_SRA  = 5'd16,
        ALU_HALT = 5'd31
    } alu_op_e;

    // loads below 8, stores from 8 up
    typedef enum logic [3:0] {
        LW       = 4'd0,
        LH       = 4'd1,
        LB       = 4'd2,
        LBU      = 4'd3,
        LHU      = 4'd4,
        SW       = 4'd8,
        SH       = 4'd9,
        SB       = 4'd11,
        MEM_NONE = 4'd15
    } dmem_e;

    typedef enum logic [3:0] {
        BEQ     = 4'd0,
        BNE     = 4'd1,
        BLT     = 4'd2,
        BLTU    = 4'd3,
        BGE     = 4'd4,
        BGEU    = 4'd6,
        JAL     = 4'd8,
        JALR    = 4'd9,
        BR_NONE = 4'd15
    } br_e;

    typedef enum logic [1:0] {
        WD_PC4  = 2'd0,
        WD_ALU  = 2'd1,
        WD_MEM  = 2'd2,
        WD_NONE = 2'd3
    } wd_sel_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_SH,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_ZERO
    } imm_fmt_e;

    typedef enum logic [`RV_OPC_W-1:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_src0_sel;
        logic      alu_src1_sel;
        dmem_e     dmem_access;
        reg_addr_t rf_ra0;
        reg_addr_t rf_ra1;
        reg_addr_t rf_wa;
        logic      rf_we;
        wd_sel_e   rf_wd_sel;
        br_e       br_type;
        word_t     imm;
        logic      halt;
        logic      illegal;
    } decode_ctrl_t;

    // bubble: zeros except the none codes
    localparam decode_ctrl_t CTRL_BUBBLE = '{
        alu_op:       ALU_ADD,
        alu_src0_sel: 1'b0,
        alu_src1_sel: 1'b0,
        dmem_access:  MEM_NONE,
        rf_ra0:       '0,
        rf_ra1:       '0,
        rf_wa:        '0,
        rf_we:        1'b0,
        rf_wd_sel:    WD_NONE,
        br_type:      BR_NONE,
        imm:          '0,
        halt:         1'b0,
        illegal:      1'b0
    };

endpackage

// File: logic/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// datapath and instruction width
`define RV_XLEN     32

// register number width, also the shamt width
`define RV_REG_AW   5

`define RV_OPC_W    7
`define RV_F3_W     3
`define RV_F7_W     7

// field positions inside the instruction word
`define RV_OPC_LSB  0
`define RV_RD_LSB   7
`define RV_F3_LSB   12
`define RV_RS1_LSB  15
`define RV_RS2_LSB  20
`define RV_F7_LSB   25

// funct7 values used by the ALU groups
`define RV_F7_BASE  7'b0000000
`define RV_F7_ALT   7'b0100000

// the one SYSTEM word that decodes
`define RV_EBREAK   32'h00100073

`endif
